// File: Makefile
# Verilator build for the serial LED string project

VERILATOR ?= verilator
TOP       ?= tb_led_string
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: common/led_regs_pkg.sv
package led_regs_pkg;

	//////////////////////////////////////////////////
	// APB bus shape

	// Byte address width
	localparam int apb_addr_bits = 8;

	// Only 32-bit data is supported
	localparam int apb_data_bits = 32;

	//////////////////////////////////////////////////
	// Framebuffer address map

	// One pixel per 32-bit word, word n at byte 4*n
	localparam int fb_word_bytes = 4;

	// Low address bits that must be zero on a write
	localparam int fb_addr_lsb = $clog2(fb_word_bytes);

	// Width of the word index part of the address
	localparam int fb_index_bits = apb_addr_bits - fb_addr_lsb;

endpackage

// File: common/led_timing_pkg.sv
package led_timing_pkg;

	//////////////////////////////////////////////////
	// LED chain geometry

	// Number of LEDs in the chain
	localparam int num_leds = 4;

	// Width of an LED index
	localparam int led_idx_bits = $clog2(num_leds);

	// One 24-bit colour per LED, sent MSB first
	localparam int pixel_bits = 24;

	// Width of a bit pointer into one pixel
	localparam int bit_idx_bits = $clog2(pixel_bits);

	//////////////////////////////////////////////////
	// Line timing in clock cycles

	// Short and long pulse lengths
	// A one is long high then short low, a zero is the reverse
	localparam int short_time = 3;
	localparam int long_time = 9;

	// Low gap ahead of each LED's first bit
	localparam int ifg_time = 20;

	// Low period that latches the whole chain at frame start
	localparam int reset_time = 75;

	// Pulse counter must reach the longest period
	localparam int count_bits = $clog2(reset_time + 1);

endpackage

// File: compile.f
common/led_timing_pkg.sv
common/led_regs_pkg.sv
hw/led_apb_regs.sv
led_serial/led_framebuffer.sv
led_serial/led_bit_encoder.sv
hw/led_string_top.sv
sim/tb_led_string.sv

// File: hw/led_apb_regs.sv
`timescale 1ns/10ps

module led_apb_regs
	import led_timing_pkg::*, led_regs_pkg::*;
(
	input  logic                     apb,
	input  logic                     reset,

	// APB completer side
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [apb_addr_bits-1:0] paddr,
	input  logic [apb_data_bits-1:0] pwdata,
	output logic                     pready,
	output logic                     pslverr,

	// Framebuffer write port
	output logic                     fb_we,
	output logic [led_idx_bits-1:0]  fb_waddr,
	output logic [pixel_bits-1:0]    fb_wdata,

	// Update request towards the LED engine
	output logic                     update_req,
	input  logic                     update_ack
);

	//////////////////////////////////////////////////
	// Access decode

	logic                     access;
	logic                     aligned;
	logic                     in_range;
	logic                     write_ok;
	logic [fb_index_bits-1:0] word_idx;

	// No wait states, every access ends in its access phase
	assign access = psel && penable;
	assign pready = access;

	assign word_idx = paddr[apb_addr_bits-1:fb_addr_lsb];
	assign aligned  = (paddr[fb_addr_lsb-1:0] == '0);
	assign in_range = (word_idx < fb_index_bits'(num_leds));

	// Only aligned in-range writes get through
	assign write_ok = access && pwrite && aligned && in_range;

	// Reads are refused, there is no readback path
	assign pslverr = access && !write_ok;

	//////////////////////////////////////////////////
	// Framebuffer write strobe

	assign fb_we    = write_ok;
	assign fb_waddr = word_idx[led_idx_bits-1:0];

	// Top byte of the bus word is ignored
	assign fb_wdata = pwdata[pixel_bits-1:0];

	//////////////////////////////////////////////////
	// Four-phase update request

	// Set by a write that lands mid-handshake
	logic dirty;

	always_ff @(posedge apb) begin
		if (reset) begin
			update_req <= 1'b0;
			dirty      <= 1'b0;
		end else begin
			// Fresh write with the handshake at rest starts a request
			if (write_ok) begin
				if (update_req || update_ack)
					dirty <= 1'b1;
				else
					update_req <= 1'b1;
			end

			// Engine has taken it, drop req
			if (update_req && update_ack)
				update_req <= 1'b0;

			// Handshake back at rest, replay a write we had to hold
			if (!update_req && !update_ack && dirty) begin
				update_req <= 1'b1;
				dirty      <= 1'b0;
			end
		end
	end

endmodule

// File: hw/led_string_top.sv
`timescale 1ns/10ps

module led_string_top
	import led_timing_pkg::*, led_regs_pkg::*;
(
	input  logic                     apb,
	input  logic                     reset,

	// APB completer
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [apb_addr_bits-1:0] paddr,
	input  logic [apb_data_bits-1:0] pwdata,
	output logic                     pready,
	output logic                     pslverr,

	// Serial LED data line
	output logic                     led_ctrl
);

	//////////////////////////////////////////////////
	// Internal wiring

	logic                    fb_we;
	logic [led_idx_bits-1:0] fb_waddr;
	logic [pixel_bits-1:0]   fb_wdata;
	logic                    fb_re;
	logic [led_idx_bits-1:0] fb_raddr;
	logic [pixel_bits-1:0]   fb_rdata;
	logic                    update_req;
	logic                    update_ack;

	// Bus decode and update requester
	led_apb_regs u_led_apb_regs (
		.apb        (apb),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.fb_we      (fb_we),
		.fb_waddr   (fb_waddr),
		.fb_wdata   (fb_wdata),
		.update_req (update_req),
		.update_ack (update_ack)
	);

	led_framebuffer u_led_framebuffer (
		.apb      (apb),
		.fb_we    (fb_we),
		.fb_waddr (fb_waddr),
		.fb_wdata (fb_wdata),
		.fb_re    (fb_re),
		.fb_raddr (fb_raddr),
		.fb_rdata (fb_rdata)
	);

	// Frame generator on the LED line
	led_bit_encoder u_led_bit_encoder (
		.apb        (apb),
		.reset      (reset),
		.update_req (update_req),
		.update_ack (update_ack),
		.fb_re      (fb_re),
		.fb_raddr   (fb_raddr),
		.fb_rdata   (fb_rdata),
		.led_ctrl   (led_ctrl)
	);

endmodule

// File: led_serial/led_bit_encoder.sv
`timescale 1ns/10ps

module led_bit_encoder
	import led_timing_pkg::*;
(
	input  logic                    apb,
	input  logic                    reset,

	// Update handshake, acknowledge side
	input  logic                    update_req,
	output logic                    update_ack,

	// Framebuffer read port
	output logic                    fb_re,
	output logic [led_idx_bits-1:0] fb_raddr,
	input  logic [pixel_bits-1:0]   fb_rdata,

	// Serial LED data line
	output logic                    led_ctrl
);

	typedef enum logic [2:0] {
		st_idle,
		st_reset,
		st_gap,
		st_high,
		st_low
	} enc_state_t;

	enc_state_t              state;
	logic                    pending;
	logic [count_bits-1:0]   count;
	logic [count_bits-1:0]   phase_last;
	logic [bit_idx_bits-1:0] bit_idx;
	logic [bit_idx_bits-1:0] next_bit;
	logic [led_idx_bits-1:0] led_idx;
	logic                    phase_done;

	// Last count value of a high phase, long for a one
	function automatic logic [count_bits-1:0] high_last(input logic bit_val);
		high_last = bit_val ? count_bits'(long_time - 1) : count_bits'(short_time - 1);
	endfunction

	// Low phase mirrors the high so every bit has the same length
	function automatic logic [count_bits-1:0] low_last(input logic bit_val);
		low_last = bit_val ? count_bits'(short_time - 1) : count_bits'(long_time - 1);
	endfunction

	assign phase_done = (count == phase_last);
	assign next_bit   = bit_idx - 1'b1;
	assign fb_raddr   = led_idx;

	//////////////////////////////////////////////////
	// Frame FSM and handshake

	always_ff @(posedge apb) begin
		if (reset) begin
			state      <= st_idle;
			// One dark frame goes out after reset
			pending    <= 1'b1;
			update_ack <= 1'b0;
			count      <= '0;
			phase_last <= '0;
			bit_idx    <= '0;
			led_idx    <= '0;
			fb_re      <= 1'b0;
			led_ctrl   <= 1'b0;
		end else begin
			count <= count + 1'b1;
			fb_re <= 1'b0;

			case (state)
				st_idle: begin
					led_ctrl <= 1'b0;
					if (pending) begin
						pending    <= 1'b0;
						count      <= '0;
						phase_last <= count_bits'(reset_time - 1);
						state      <= st_reset;
					end
				end

				// Long low to latch the chain
				st_reset: begin
					if (phase_done) begin
						// Fetch LED 0 while the gap runs
						led_idx    <= '0;
						fb_re      <= 1'b1;
						bit_idx    <= bit_idx_bits'(pixel_bits - 1);
						count      <= '0;
						phase_last <= count_bits'(ifg_time - 1);
						state      <= st_gap;
					end
				end

				st_gap: begin
					if (phase_done) begin
						led_ctrl   <= 1'b1;
						count      <= '0;
						phase_last <= high_last(fb_rdata[bit_idx]);
						state      <= st_high;
					end
				end

				st_high: begin
					if (phase_done) begin
						led_ctrl   <= 1'b0;
						count      <= '0;
						phase_last <= low_last(fb_rdata[bit_idx]);
						state      <= st_low;
					end
				end

				st_low: begin
					if (phase_done) begin
						count <= '0;
						if (bit_idx != '0) begin
							// Next bit of this pixel
							bit_idx    <= next_bit;
							led_ctrl   <= 1'b1;
							phase_last <= high_last(fb_rdata[next_bit]);
							state      <= st_high;
						end else if (led_idx == led_idx_bits'(num_leds - 1)) begin
							state <= st_idle;
						end else begin
							// On to the next LED, read its pixel during the gap
							led_idx    <= led_idx + 1'b1;
							fb_re      <= 1'b1;
							bit_idx    <= bit_idx_bits'(pixel_bits - 1);
							phase_last <= count_bits'(ifg_time - 1);
							state      <= st_gap;
						end
					end
				end

				default: state <= st_idle;
			endcase

			// Ack side runs in every state
			// A new request wins over the pending clear in idle
			if (update_req && !update_ack) begin
				update_ack <= 1'b1;
				pending    <= 1'b1;
			end else if (!update_req && update_ack) begin
				update_ack <= 1'b0;
			end
		end
	end

endmodule

// File: led_serial/led_framebuffer.sv
`timescale 1ns/10ps

module led_framebuffer
	import led_timing_pkg::*;
(
	input  logic                    apb,

	// Write port from the register block
	input  logic                    fb_we,
	input  logic [led_idx_bits-1:0] fb_waddr,
	input  logic [pixel_bits-1:0]   fb_wdata,

	// Registered read port for the LED engine
	input  logic                    fb_re,
	input  logic [led_idx_bits-1:0] fb_raddr,
	output logic [pixel_bits-1:0]   fb_rdata = '0
);

	//////////////////////////////////////////////////
	// Pixel storage

	// Pixels power up dark so the first frame is all zero
	logic [pixel_bits-1:0] mem [num_leds] = '{default: '0};

	always_ff @(posedge apb) begin
		if (fb_we)
			mem[fb_waddr] <= fb_wdata;

		// Read data held until the next read strobe
		if (fb_re)
			fb_rdata <= mem[fb_raddr];
	end

endmodule

// File: sim/tb_led_string.sv
`timescale 1ns/10ps

module tb_led_string
	import led_timing_pkg::*, led_regs_pkg::*;
();

	//////////////////////////////////////////////////
	// Run length and clocking

	localparam int clk_half     = 4;
	localparam int bit_cycles   = short_time + long_time;
	localparam int frame_cycles = reset_time + num_leds * (ifg_time + pixel_bits * bit_cycles);
	// Room for about nine frames where the sequence needs about six
	localparam int max_cycles   = 9 * frame_cycles + 200;

	logic                     apb = 1'b0;
	logic                     reset;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	logic [apb_addr_bits-1:0] paddr;
	logic [apb_data_bits-1:0] pwdata;
	logic                     pready;
	logic                     pslverr;
	logic                     led_ctrl;

	// Expected pslverr of the access in flight
	logic                  exp_err = 1'b0;
	logic [31:0]           seed = 32'h2a5416da;
	logic [pixel_bits-1:0] model [num_leds];
	int bus_errs = 0;
	int pulse_errs = 0;
	int data_errs = 0;
	int run_cycles = 0;
	int quiet_cnt = 0;

	// Pulse decoder state
	logic                  line_q = 1'b0;
	logic [pixel_bits-1:0] word = '0;
	logic [pixel_bits-1:0] words [num_leds];
	int run_len = 0;
	int last_high = 0;
	int bit_cnt = 0;
	bit in_frame = 1'b0;
	int frame_rise = 0;
	int cycle = 0;
	int last_write = 0;
	int frames_checked = 0;

	always #clk_half apb = ~apb;

	led_string_top u_led_string_top (
		.apb     (apb),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pready  (pready),
		.pslverr (pslverr),
		.led_ctrl(led_ctrl)
	);

	//////////////////////////////////////////////////
	// Bus checks

	a_pready: assert property (@(posedge apb) (psel && penable) |-> pready) else begin
		bus_errs++;
		$display("error t=%0t signal=pready expected=1 actual=%0b", $time, pready);
	end

	a_pslverr: assert property (@(posedge apb) (psel && penable) |-> (pslverr == exp_err)) else begin
		bus_errs++;
		$display("error t=%0t signal=pslverr expected=%0b actual=%0b", $time, exp_err, pslverr);
	end

	// Outside an access phase the bus stays quiet
	a_pready_idle: assert property (@(posedge apb) !(psel && penable) |-> !pready) else begin
		bus_errs++;
		$display("error t=%0t signal=pready expected=0 actual=%0b", $time, pready);
	end

	a_pslverr_idle: assert property (@(posedge apb) !(psel && penable) |-> !pslverr) else begin
		bus_errs++;
		$display("error t=%0t signal=pslverr expected=0 actual=%0b", $time, pslverr);
	end

	// Line held low through reset and the first reset period
	always @(posedge apb) begin
		if (reset)
			quiet_cnt <= 0;
		else if (quiet_cnt < reset_time)
			quiet_cnt <= quiet_cnt + 1;
	end

	a_quiet: assert property (@(posedge apb) (reset || quiet_cnt < reset_time) |-> led_ctrl !== 1'b1)
	else begin
		pulse_errs++;
		$display("error t=%0t signal=led_ctrl expected=0 actual=%0b", $time, led_ctrl);
	end

	//////////////////////////////////////////////////
	// Pulse decoder sampled mid-cycle

	// Frame compared only when its reset period began after the last accepted write
	task automatic check_frame;
		in_frame = 1'b0;
		if (last_write + reset_time + ifg_time <= frame_rise) begin
			for (int i = 0; i < num_leds; i++) begin
				assert (words[i] == model[i]) else begin
					data_errs++;
					$display("error t=%0t signal=led_ctrl led %0d expected=%06h actual=%06h",
						$time, i, model[i], words[i]);
				end
			end
			frames_checked++;
		end
	endtask

	always @(negedge apb) begin
		if (led_ctrl === line_q) begin
			run_len = run_len + 1;
		end else if (line_q) begin
			// High just ended and its length gives the bit
			assert (run_len == short_time || run_len == long_time) else begin
				pulse_errs++;
				$display("error t=%0t signal=led_ctrl high cycles expected=%0d or %0d actual=%0d",
					$time, short_time, long_time, run_len);
			end
			assert (in_frame) else begin
				pulse_errs++;
				$display("Bit pulse seen outside a frame at t=%0t", $time);
			end
			if (in_frame) begin
				word = {word[pixel_bits-2:0], run_len == long_time};
				last_high = run_len;
				bit_cnt++;
				if (bit_cnt % pixel_bits == 0)
					words[bit_cnt / pixel_bits - 1] = word;
				if (bit_cnt == num_leds * pixel_bits)
					check_frame();
			end
			run_len = 1;
		end else begin
			// Low just ended
			if (run_len >= reset_time) begin
				assert (!in_frame) else begin
					pulse_errs++;
					$display("Frame cut short after %0d bits at t=%0t", bit_cnt, $time);
				end
				in_frame = 1'b1;
				bit_cnt = 0;
				frame_rise = cycle;
			end else if (in_frame && bit_cnt % pixel_bits == 0) begin
				// Last bit's low runs into the next LED's gap
				assert (run_len + last_high == bit_cycles + ifg_time) else begin
					pulse_errs++;
					$display("error t=%0t signal=led_ctrl gap low expected=%0d actual=%0d",
						$time, bit_cycles + ifg_time - last_high, run_len);
				end
			end else if (in_frame) begin
				assert (run_len + last_high == bit_cycles) else begin
					pulse_errs++;
					$display("error t=%0t signal=led_ctrl bit low expected=%0d actual=%0d",
						$time, bit_cycles - last_high, run_len);
				end
			end else begin
				pulse_errs++;
				$display("Pulse without a reset low before it at t=%0t", $time);
			end
			run_len = 1;
		end
		line_q = led_ctrl;
		cycle = cycle + 1;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One setup and one access cycle with inputs moved 1 ns after the edge
	task automatic bus_access(input logic write, input logic [apb_addr_bits-1:0] addr,
		input logic [apb_data_bits-1:0] data);
		logic ok;
		ok = write && (addr % fb_word_bytes == 0) && (int'(addr) / fb_word_bytes < num_leds);
		exp_err = !ok;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(posedge apb);
		#1 penable = 1'b1;
		@(posedge apb);
		if (ok) begin
			model[int'(addr) / fb_word_bytes] = data[pixel_bits-1:0];
			last_write = cycle;
		end
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [apb_addr_bits-1:0] addr,
		input logic [apb_data_bits-1:0] data);
		bus_access(1'b1, addr, data);
	endtask

	task automatic apb_read(input logic [apb_addr_bits-1:0] addr);
		bus_access(1'b0, addr, '0);
	endtask

	task automatic write_random_pixel(input int idx);
		seed = xorshift32(seed);
		apb_write(apb_addr_bits'(idx * fb_word_bytes), seed);
	endtask

	task automatic wait_fresh_frame;
		int start;
		start = frames_checked;
		while (frames_checked == start)
			@(posedge apb);
		#1;
	endtask

	task automatic wait_mid_frame;
		while (!(in_frame && bit_cnt >= 40))
			@(posedge apb);
		#1;
	endtask

	//////////////////////////////////////////////////
	// Timeout

	always @(posedge apb) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= max_cycles) begin
			$display("Timeout after %0d cycles with %0d frames checked", run_cycles, frames_checked);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		for (int i = 0; i < num_leds; i++)
			model[i] = '0;
		repeat (3) @(posedge apb);
		#1 reset = 1'b0;

		// Dark frame after reset
		wait_fresh_frame();

		// Random colour on every LED
		for (int i = 0; i < num_leds; i++)
			write_random_pixel(i);
		wait_fresh_frame();

		// Refused accesses and then one good write to start a frame
		apb_read(8'h00);
		apb_read(8'h08);
		apb_write(8'h05, xorshift32(seed ^ 32'h1));
		apb_write(8'h0a, xorshift32(seed ^ 32'h2));
		apb_write(apb_addr_bits'(num_leds * fb_word_bytes), xorshift32(seed ^ 32'h3));
		apb_write(8'hfc, xorshift32(seed ^ 32'h4));
		write_random_pixel(num_leds - 1);
		wait_fresh_frame();

		// Writes that land while a frame is on the line
		write_random_pixel(2);
		wait_mid_frame();
		for (int i = 0; i < num_leds; i++)
			write_random_pixel(i);
		write_random_pixel(1);
		wait_fresh_frame();

		$display("Bus errors %0d, pulse errors %0d, data errors %0d, frames checked %0d",
			bus_errs, pulse_errs, data_errs, frames_checked);
		if (bus_errs + pulse_errs + data_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
